/* bench/decode_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "decode_params.svh"

module decode_tb import decode_pkg::*; ();

  localparam logic [2:0] K_R  = 3'd0; // encoding formats used to build words
  localparam logic [2:0] K_I  = 3'd1;
  localparam logic [2:0] K_SH = 3'd2; // shift-immediate, funct7 lives in the immediate
  localparam logic [2:0] K_S  = 3'd3;
  localparam logic [2:0] K_B  = 3'd4;
  localparam logic [2:0] K_U  = 3'd5;
  localparam logic [2:0] K_J  = 3'd6;

  logic      clk = 1'b0;
  logic      reset;
  fe_latch_t from_fe;
  wb_to_de_t from_wb;
  de_to_fe_t to_fe;
  de_latch_t de_out;

  // current word and what it should decode to
  logic [`DBITS-1:0]     cur_inst;
  iop_t                  cur_op;
  logic [`DBITS-1:0]     cur_imm;
  logic [`REGNOBITS-1:0] cur_rd;
  logic                  cur_u1;
  logic                  cur_u2;
  logic                  cur_wr;

  // reference model state
  logic [`DBITS-1:0]    shadow [`REGWORDS];
  logic [`REGWORDS-1:0] busy_m;
  logic                 pred_stall;
  logic                 pred_accept;
  logic [`DBITS-1:0]    pred_rs1;
  logic [`DBITS-1:0]    pred_rs2;
  iop_t                 pred_op;
  logic [`DBITS-1:0]    pred_imm;
  logic                 pred_wr;
  logic [`REGNOBITS-1:0] pred_rd;
  logic                 exp_valid;
  logic [`DBITS-1:0]    exp_inst;
  logic [`DBITS-1:0]    exp_pc;
  logic [`DBITS-1:0]    exp_pcplus;
  logic [`DBITS-1:0]    exp_count;
  iop_t                 exp_op;
  logic [`DBITS-1:0]    exp_imm;
  logic [`REGNOBITS-1:0] exp_rd;
  logic                 exp_wr;
  logic [`DBITS-1:0]    exp_rs1;
  logic [`DBITS-1:0]    exp_rs2;
  int unsigned          count;

  decode_stage u_dut (
    .clk     (clk),
    .reset   (reset),
    .from_fe (from_fe),
    .from_wb (from_wb),
    .to_fe   (to_fe),
    .de_out  (de_out)
  );

  always #2 clk = ~clk;

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic mismatch(input string msg);
    stop_run($sformatf("Mismatch at %0t ns: %s", $time, msg));
  endtask

  a_stall: assert property (@(posedge clk) disable iff (reset) to_fe.stall == pred_stall)
    else mismatch("stall differs from the scoreboard model");
  a_valid: assert property (@(posedge clk) disable iff (reset) de_out.valid == exp_valid)
    else mismatch("de_out.valid differs from the model");
  a_decode: assert property (@(posedge clk) disable iff (reset)
      exp_valid |-> (de_out.op == exp_op && de_out.imm == exp_imm &&
                     de_out.rd == exp_rd && de_out.wr_reg == exp_wr))
    else mismatch("op, imm, rd or wr_reg wrong in de_out");
  a_fetch: assert property (@(posedge clk) disable iff (reset)
      exp_valid |-> (de_out.inst == exp_inst && de_out.pc == exp_pc &&
                     de_out.pcplus == exp_pcplus && de_out.inst_count == exp_count))
    else mismatch("inst, pc, pcplus or inst_count wrong in de_out");
  a_regs: assert property (@(posedge clk) disable iff (reset)
      exp_valid |-> (de_out.rs1_val == exp_rs1 && de_out.rs2_val == exp_rs2))
    else mismatch("register read value wrong in de_out");
  a_bubble: assert property (@(posedge clk) disable iff (reset) !exp_valid |-> de_out == '0)
    else mismatch("bubble in de_out is not all zero");

  function automatic logic [`REGNOBITS-1:0] rand_reg();
    logic [31:0] t;
    t = $urandom();
    return t[`REGNOBITS-1:0];
  endfunction

  function automatic logic [`DBITS-1:0] read_model(input logic [`REGNOBITS-1:0] r);
    if (r == '0)
      return '0;
    else if (from_wb.wr_reg && from_wb.wregno == r)
      return from_wb.regval; // write-back in the same cycle reads through
    else
      return shadow[r];
  endfunction

  // expected stall, reads and decode for whatever is on the inputs now
  task automatic predict();
    logic [`REGNOBITS-1:0] s1;
    logic [`REGNOBITS-1:0] s2;
    logic h1;
    logic h2;
    s1 = from_fe.inst[19:15];
    s2 = from_fe.inst[24:20];
    h1 = cur_u1 && s1 != '0 && busy_m[s1] && !(from_wb.wr_reg && from_wb.wregno == s1);
    h2 = cur_u2 && s2 != '0 && busy_m[s2] && !(from_wb.wr_reg && from_wb.wregno == s2);
    pred_stall  = from_fe.valid && (h1 || h2);
    pred_accept = from_fe.valid && !pred_stall;
    pred_rs1    = read_model(s1);
    pred_rs2    = read_model(s2);
    pred_op     = cur_op;
    pred_imm    = cur_imm;
    pred_wr     = cur_wr;
    pred_rd     = cur_rd;
  endtask

  always @(posedge clk) begin : model_update
    logic [`REGWORDS-1:0] nb;
    if (reset) begin
      exp_valid <= 1'b0;
      busy_m    <= '0;
      for (int i = 0; i < `REGWORDS; i++)
        shadow[i] <= '0;
    end else begin
      exp_valid  <= pred_accept;
      exp_inst   <= from_fe.inst;
      exp_pc     <= from_fe.pc;
      exp_pcplus <= from_fe.pcplus;
      exp_count  <= from_fe.inst_count;
      exp_op     <= pred_op;
      exp_imm    <= pred_imm;
      exp_rd     <= pred_rd;
      exp_wr     <= pred_wr;
      exp_rs1    <= pred_rs1;
      exp_rs2    <= pred_rs2;
      if (from_wb.wr_reg && from_wb.wregno != '0)
        shadow[from_wb.wregno] <= from_wb.regval;
      nb = busy_m;
      if (from_wb.wr_reg)
        nb[from_wb.wregno] = 1'b0;
      if (pred_accept && pred_wr && pred_rd != '0)
        nb[pred_rd] = 1'b1; // issue wins over a clear in the same cycle
      busy_m <= nb;
    end
  end

  task automatic drive(input logic v, input logic [`DBITS-1:0] inst, input logic we,
                       input logic [`REGNOBITS-1:0] wno, input logic [`DBITS-1:0] wval);
    @(negedge clk);
    count              = count + 1;
    from_fe.valid      = v;
    from_fe.inst       = inst;
    from_fe.pc         = 32'h0000_1000 + (count << 2);
    from_fe.pcplus     = 32'h0000_1004 + (count << 2);
    from_fe.inst_count = count;
    from_wb.wr_reg     = we;
    from_wb.wregno     = wno;
    from_wb.regval     = wval;
    predict();
  endtask

  // build a word for op from its spec encoding, with a random immediate
  task automatic encode(input iop_t op, input logic [`REGNOBITS-1:0] rd,
                        input logic [`REGNOBITS-1:0] rs1, input logic [`REGNOBITS-1:0] rs2);
    logic [19:0] info; // opcode, funct3, funct7, format
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [2:0]  kind;
    logic [31:0] rnd;
    rnd = $urandom();
    case (op)
      iop_add:   info = {7'b0110011, 3'b000, 7'b0000000, K_R};
      iop_sub:   info = {7'b0110011, 3'b000, 7'b0100000, K_R};
      iop_and:   info = {7'b0110011, 3'b111, 7'b0000000, K_R};
      iop_or:    info = {7'b0110011, 3'b110, 7'b0000000, K_R};
      iop_xor:   info = {7'b0110011, 3'b100, 7'b0000000, K_R};
      iop_slt:   info = {7'b0110011, 3'b010, 7'b0000000, K_R};
      iop_sltu:  info = {7'b0110011, 3'b011, 7'b0000000, K_R};
      iop_sra:   info = {7'b0110011, 3'b101, 7'b0100000, K_R};
      iop_srl:   info = {7'b0110011, 3'b101, 7'b0000000, K_R};
      iop_sll:   info = {7'b0110011, 3'b001, 7'b0000000, K_R};
      iop_mul:   info = {7'b0110011, 3'b000, 7'b0000001, K_R};
      iop_addi:  info = {7'b0010011, 3'b000, 7'b0000000, K_I};
      iop_andi:  info = {7'b0010011, 3'b111, 7'b0000000, K_I};
      iop_ori:   info = {7'b0010011, 3'b110, 7'b0000000, K_I};
      iop_xori:  info = {7'b0010011, 3'b100, 7'b0000000, K_I};
      iop_slti:  info = {7'b0010011, 3'b010, 7'b0000000, K_I};
      iop_sltiu: info = {7'b0010011, 3'b011, 7'b0000000, K_I};
      iop_srai:  info = {7'b0010011, 3'b101, 7'b0100000, K_SH};
      iop_srli:  info = {7'b0010011, 3'b101, 7'b0000000, K_SH};
      iop_slli:  info = {7'b0010011, 3'b001, 7'b0000000, K_SH};
      iop_lui:   info = {7'b0110111, 3'b000, 7'b0000000, K_U};
      iop_auipc: info = {7'b0010111, 3'b000, 7'b0000000, K_U};
      iop_jal:   info = {7'b1101111, 3'b000, 7'b0000000, K_J};
      iop_jalr:  info = {7'b1100111, 3'b000, 7'b0000000, K_I};
      iop_beq:   info = {7'b1100011, 3'b000, 7'b0000000, K_B};
      iop_bne:   info = {7'b1100011, 3'b001, 7'b0000000, K_B};
      iop_blt:   info = {7'b1100011, 3'b100, 7'b0000000, K_B};
      iop_bge:   info = {7'b1100011, 3'b101, 7'b0000000, K_B};
      iop_bltu:  info = {7'b1100011, 3'b110, 7'b0000000, K_B};
      iop_bgeu:  info = {7'b1100011, 3'b111, 7'b0000000, K_B};
      iop_lw:    info = {7'b0000011, 3'b010, 7'b0000000, K_I};
      default:   info = {7'b0100011, 3'b010, 7'b0000000, K_S}; // sw
    endcase
    {opc, f3, f7, kind} = info;
    cur_op = op;
    cur_u1 = kind != K_U && kind != K_J;
    cur_u2 = kind == K_R || kind == K_S || kind == K_B;
    cur_wr = kind != K_S && kind != K_B;
    cur_rd = rd;
    case (kind)
      K_R: begin
        cur_inst = {f7, rs2, rs1, f3, rd, opc};
        cur_imm  = '0;
      end
      K_I: begin
        cur_inst = {rnd[11:0], rs1, f3, rd, opc};
        cur_imm  = {{20{rnd[11]}}, rnd[11:0]};
      end
      K_SH: begin
        cur_inst = {f7, rnd[4:0], rs1, f3, rd, opc};
        cur_imm  = {20'b0, f7, rnd[4:0]};
      end
      K_S: begin
        cur_inst = {rnd[11:5], rs2, rs1, f3, rnd[4:0], opc};
        cur_imm  = {{20{rnd[11]}}, rnd[11:0]};
        cur_rd   = rnd[4:0]; // rd field carries low immediate bits
      end
      K_B: begin
        cur_inst = {rnd[12], rnd[10:5], rs2, rs1, f3, rnd[4:1], rnd[11], opc};
        cur_imm  = {{19{rnd[12]}}, rnd[12:1], 1'b0};
        cur_rd   = {rnd[4:1], rnd[11]};
      end
      K_U: begin
        cur_inst = {rnd[31:12], rd, opc};
        cur_imm  = {rnd[31:12], 12'b0};
      end
      default: begin
        cur_inst = {rnd[20], rnd[10:1], rnd[11], rnd[19:12], rd, opc};
        cur_imm  = {{11{rnd[20]}}, rnd[20:1], 1'b0};
      end
    endcase
  endtask

  task automatic set_invalid(input logic [`DBITS-1:0] w);
    cur_inst = w;
    cur_op   = iop_invalid;
    cur_imm  = '0;
    cur_rd   = w[11:7];
    cur_u1   = 1'b0;
    cur_u2   = 1'b0;
    cur_wr   = 1'b0;
  endtask

  // present cur_inst until accepted, releasing a busy source after hold stalled cycles
  task automatic issue(input int hold, input logic we, input logic [`REGNOBITS-1:0] wno,
                       input logic [`DBITS-1:0] wval);
    int waited;
    logic [`REGNOBITS-1:0] r;
    waited = 0;
    drive(1'b1, cur_inst, we, wno, wval);
    while (pred_stall) begin
      waited++;
      r = (cur_u1 && cur_inst[19:15] != '0 && busy_m[cur_inst[19:15]]) ?
          cur_inst[19:15] : cur_inst[24:20];
      if (waited > 50)
        stop_run("Timed out: the held instruction was never accepted");
      else if (waited > hold)
        drive(1'b1, cur_inst, 1'b1, r, $urandom());
      else
        drive(1'b1, cur_inst, 1'b0, '0, '0);
    end
  endtask

  task automatic write_all();
    for (int r = 0; r < `REGWORDS; r++)
      drive(1'b0, '0, 1'b1, r[`REGNOBITS-1:0], $urandom());
  endtask

  initial begin
    int unsigned seed_sink;
    logic [31:0] w;
    seed_sink = $urandom(19975);
    reset   = 1'b1;
    from_fe = '0;
    from_wb = '0;
    count   = 0;
    set_invalid('0);
    pred_stall  = 1'b0;
    pred_accept = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    repeat (6) drive(1'b0, '0, 1'b0, '0, '0); // idle after reset

    // register reads, same-cycle write-through and x0
    write_all();
    for (int r = 0; r < `REGWORDS; r++) begin
      encode(iop_add, 5'd0, r[4:0], 5'd31 - r[4:0]);
      issue(0, 1'b0, '0, '0);
    end
    encode(iop_add, 5'd3, 5'd7, 5'd7);
    issue(0, 1'b1, 5'd7, 32'h1234_5678);
    drive(1'b0, '0, 1'b1, 5'd0, 32'hdead_beef);
    encode(iop_add, 5'd1, 5'd0, 5'd0);
    issue(0, 1'b1, 5'd0, 32'hcafe_f00d);

    // unsupported words never stall and leave no busy bit behind
    write_all();
    for (int i = 0; i < 24; i++) begin
      w = $urandom();
      case (i % 4)
        0: w[6:0] = 7'b1110011; // csr and system
        1: w[6:0] = 7'b0001111;
        2: w[14:12] = 3'b010 | 3'((i / 4) % 2); // branch funct3 010 or 011
        default: w[31:25] = 7'b0000001; // m-extension beyond mul
      endcase
      if (i % 4 == 2)
        w[6:0] = 7'b1100011;
      if (i % 4 == 3) begin
        w[6:0] = 7'b0110011;
        w[14:12] = 3'd1 + 3'(i % 7);
      end
      set_invalid(w);
      issue(0, 1'b0, '0, '0);
      encode(iop_add, 5'd0, w[11:7], w[11:7]);
      issue(0, 1'b0, '0, '0);
    end

    // every supported op with random fields
    for (int k = 0; k <= int'(iop_sw); k++) begin
      repeat (5) begin
        encode(iop_t'(k), rand_reg(), rand_reg(), rand_reg());
        issue(0, 1'b0, '0, '0);
      end
    end

    // read-after-write hazards held until write-back
    write_all();
    encode(iop_addi, 5'd9, 5'd0, 5'd0);
    issue(0, 1'b0, '0, '0);
    encode(iop_add, 5'd10, 5'd9, 5'd2);
    issue(3, 1'b0, '0, '0);
    encode(iop_sw, 5'd0, 5'd4, 5'd10);
    issue(2, 1'b0, '0, '0);

    // x0 and unrelated registers never stall on a busy x12
    encode(iop_addi, 5'd12, 5'd0, 5'd0);
    issue(0, 1'b0, '0, '0);
    encode(iop_add, 5'd13, 5'd0, 5'd0);
    issue(0, 1'b0, '0, '0);
    encode(iop_addi, 5'd0, 5'd5, 5'd0);
    issue(0, 1'b0, '0, '0);
    encode(iop_sub, 5'd14, 5'd5, 5'd6);
    issue(0, 1'b0, '0, '0);
    encode(iop_lui, 5'd12, 5'd0, 5'd0);
    issue(0, 1'b0, '0, '0);
    encode(iop_jal, 5'd0, 5'd0, 5'd0);
    issue(0, 1'b0, '0, '0);

    repeat (4) drive(1'b0, '0, 1'b0, '0, '0);
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* common/decode_params.svh */
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

`define DBITS      32 // data and pc width
`define REGWORDS   32
`define REGNOBITS  5

// major opcodes, inst[6:0]
`define R_OPCODE      7'b0110011
`define IMM_OPCODE    7'b0010011
`define LUI_OPCODE    7'b0110111
`define AUIPC_OPCODE  7'b0010111
`define JAL_OPCODE    7'b1101111
`define JALR_OPCODE   7'b1100111
`define BRANCH_OPCODE 7'b1100011
`define LW_OPCODE     7'b0000011
`define SW_OPCODE     7'b0100011

// alu funct3, shared by register and immediate forms
`define ADD_FUNCT3  3'b000
`define SLL_FUNCT3  3'b001
`define SLT_FUNCT3  3'b010
`define SLTU_FUNCT3 3'b011
`define XOR_FUNCT3  3'b100
`define SRL_FUNCT3  3'b101 // also sra
`define OR_FUNCT3   3'b110
`define AND_FUNCT3  3'b111
`define MUL_FUNCT3  3'b000

`define BEQ_FUNCT3  3'b000
`define BNE_FUNCT3  3'b001
`define BLT_FUNCT3  3'b100
`define BGE_FUNCT3  3'b101
`define BLTU_FUNCT3 3'b110
`define BGEU_FUNCT3 3'b111
`define LW_FUNCT3   3'b010
`define SW_FUNCT3   3'b010
`define JALR_FUNCT3 3'b000

`define BASE_FUNCT7 7'b0000000
`define SUB_FUNCT7  7'b0100000 // sub, sra, srai
`define MUL_FUNCT7  7'b0000001

`endif

/* common/decode_pkg.sv */
`default_nettype none

`include "decode_params.svh"

package decode_pkg;

  // internal op, one per supported instruction
  typedef enum logic [5:0] {
    iop_add, iop_sub, iop_and, iop_or, iop_xor,
    iop_slt, iop_sltu, iop_sra, iop_srl, iop_sll, iop_mul,
    iop_addi, iop_andi, iop_ori, iop_xori, iop_slti,
    iop_sltiu, iop_srai, iop_srli, iop_slli,
    iop_lui, iop_auipc, iop_jal, iop_jalr,
    iop_beq, iop_bne, iop_blt, iop_bge, iop_bltu, iop_bgeu,
    iop_lw, iop_sw,
    iop_invalid
  } iop_t;

  // instruction format, only used to steer immediate and register use
  typedef enum logic [2:0] {
    fmt_none, fmt_r, fmt_i, fmt_s, fmt_b, fmt_u, fmt_j
  } fmt_t;

  typedef enum logic [2:0] {
    imm_none, imm_i, imm_s, imm_b, imm_u, imm_j
  } imm_kind_t;

  typedef struct packed {
    logic              valid;
    logic [`DBITS-1:0] inst;
    logic [`DBITS-1:0] pc;
    logic [`DBITS-1:0] pcplus;
    logic [`DBITS-1:0] inst_count;
  } fe_latch_t;

  typedef struct packed {
    logic                 wr_reg;
    logic [`REGNOBITS-1:0] wregno;
    logic [`DBITS-1:0]    regval;
  } wb_to_de_t;

  typedef struct packed {
    logic                 valid;
    logic [`DBITS-1:0]    inst;
    logic [`DBITS-1:0]    pc;
    logic [`DBITS-1:0]    pcplus;
    logic [`DBITS-1:0]    inst_count;
    iop_t                 op;
    logic [`REGNOBITS-1:0] rd;
    logic                 wr_reg;
    logic [`DBITS-1:0]    rs1_val;
    logic [`DBITS-1:0]    rs2_val;
    logic [`DBITS-1:0]    imm;
  } de_latch_t;

  typedef struct packed {
    logic stall; // level back to fetch
  } de_to_fe_t;

endpackage

`default_nettype wire

/* decode/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "decode_params.svh"

module decode_stage import decode_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  fe_latch_t from_fe,
  input  wb_to_de_t from_wb,
  output de_to_fe_t to_fe,
  output de_latch_t de_out
);

  logic [`REGNOBITS-1:0] rs1;
  logic [`REGNOBITS-1:0] rs2;
  logic [`REGNOBITS-1:0] rd;
  iop_t                  op;
  imm_kind_t             imm_kind;
  logic                  uses_rs1;
  logic                  uses_rs2;
  logic                  wr_reg;
  logic [`DBITS-1:0]     imm;
  logic [`DBITS-1:0]     rs1_val;
  logic [`DBITS-1:0]     rs2_val;
  logic                  stall;
  logic                  accept;
  de_latch_t             de_next;

  assign rs1 = from_fe.inst[19:15];
  assign rs2 = from_fe.inst[24:20];
  assign rd  = from_fe.inst[11:7];

  instr_decoder u_decoder (
    .inst     (from_fe.inst),
    .op       (op),
    .imm_kind (imm_kind),
    .uses_rs1 (uses_rs1),
    .uses_rs2 (uses_rs2),
    .wr_reg   (wr_reg)
  );

  imm_gen u_imm_gen (
    .inst     (from_fe.inst),
    .imm_kind (imm_kind),
    .imm      (imm)
  );

  reg_file u_reg_file (
    .clk     (clk),
    .reset   (reset),
    .rs1     (rs1),
    .rs2     (rs2),
    .rs1_val (rs1_val),
    .rs2_val (rs2_val),
    .wb      (from_wb)
  );

  hazard_scoreboard u_scoreboard (
    .clk      (clk),
    .reset    (reset),
    .in_valid (from_fe.valid),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (rd),
    .uses_rs1 (uses_rs1),
    .uses_rs2 (uses_rs2),
    .wr_reg   (wr_reg),
    .wb       (from_wb),
    .stall    (stall)
  );

  assign to_fe.stall = stall;
  assign accept      = from_fe.valid && !stall; // fetch holds the word while stalled

  always_comb begin
    de_next.valid      = 1'b1;
    de_next.inst       = from_fe.inst;
    de_next.pc         = from_fe.pc;
    de_next.pcplus     = from_fe.pcplus;
    de_next.inst_count = from_fe.inst_count;
    de_next.op         = op;
    de_next.rd         = rd;
    de_next.wr_reg     = wr_reg;
    de_next.rs1_val    = rs1_val;
    de_next.rs2_val    = rs2_val;
    de_next.imm        = imm;
  end

  // bubble is the all-zero latch
  always_ff @(posedge clk) begin
    if (reset || !accept)
      de_out <= '0;
    else
      de_out <= de_next;
  end

endmodule

`default_nettype wire

/* decode/hazard_scoreboard.sv */
`timescale 1ns/1ps
`default_nettype none

`include "decode_params.svh"

module hazard_scoreboard import decode_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  in_valid,
  input  logic [`REGNOBITS-1:0] rs1,
  input  logic [`REGNOBITS-1:0] rs2,
  input  logic [`REGNOBITS-1:0] rd,
  input  logic                  uses_rs1,
  input  logic                  uses_rs2,
  input  logic                  wr_reg,
  input  wb_to_de_t             wb,
  output logic                  stall
);

  localparam logic [`REGWORDS-1:0] ONE = {{(`REGWORDS-1){1'b0}}, 1'b1};

  logic [`REGWORDS-1:0] busy;     // one bit per register still owed a write-back
  logic [`REGWORDS-1:0] set_mask;
  logic [`REGWORDS-1:0] clr_mask;
  logic rs1_hit;
  logic rs2_hit;
  logic accept;

  // a source being written back this cycle is already readable
  assign rs1_hit = uses_rs1 && rs1 != '0 && busy[rs1] && !(wb.wr_reg && wb.wregno == rs1);
  assign rs2_hit = uses_rs2 && rs2 != '0 && busy[rs2] && !(wb.wr_reg && wb.wregno == rs2);

  assign stall  = in_valid && (rs1_hit || rs2_hit);
  assign accept = in_valid && !stall;

  assign set_mask = (accept && wr_reg && rd != '0) ? (ONE << rd) : '0;
  assign clr_mask = wb.wr_reg ? (ONE << wb.wregno) : '0;

  always_ff @(posedge clk) begin
    if (reset)
      busy <= '0;
    else
      busy <= (busy & ~clr_mask) | set_mask; // new issue beats a same-cycle clear
  end

endmodule

`default_nettype wire

/* decode/imm_gen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "decode_params.svh"

module imm_gen import decode_pkg::*; (
  input  logic [`DBITS-1:0] inst,
  input  imm_kind_t         imm_kind,
  output logic [`DBITS-1:0] imm
);

  logic sign;

  assign sign = inst[31];

  always_comb begin
    case (imm_kind)
      imm_i:
        imm = {{(`DBITS-12){sign}}, inst[31:20]};
      imm_s:
        imm = {{(`DBITS-12){sign}}, inst[31:25], inst[11:7]};
      imm_b: // bit 0 is always zero for branch targets
        imm = {{(`DBITS-12){sign}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      imm_u:
        imm = {inst[31:12], 12'b0};
      imm_j:
        imm = {{(`DBITS-20){sign}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      default:
        imm = '0;
    endcase
  end

endmodule

`default_nettype wire

/* decode/instr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "decode_params.svh"

module instr_decoder import decode_pkg::*; (
  input  logic [`DBITS-1:0] inst,
  output iop_t              op,
  output imm_kind_t         imm_kind,
  output logic              uses_rs1,
  output logic              uses_rs2,
  output logic              wr_reg
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  fmt_t       fmt;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  always_comb begin
    op = iop_invalid;
    case (opcode)
      `R_OPCODE: begin
        if (funct7 == `BASE_FUNCT7) begin
          case (funct3)
            `ADD_FUNCT3:  op = iop_add;
            `SLL_FUNCT3:  op = iop_sll;
            `SLT_FUNCT3:  op = iop_slt;
            `SLTU_FUNCT3: op = iop_sltu;
            `XOR_FUNCT3:  op = iop_xor;
            `SRL_FUNCT3:  op = iop_srl;
            `OR_FUNCT3:   op = iop_or;
            `AND_FUNCT3:  op = iop_and;
            default:      op = iop_invalid;
          endcase
        end else if (funct7 == `SUB_FUNCT7) begin
          if (funct3 == `ADD_FUNCT3)
            op = iop_sub;
          else if (funct3 == `SRL_FUNCT3)
            op = iop_sra;
        end else if (funct7 == `MUL_FUNCT7 && funct3 == `MUL_FUNCT3) begin
          op = iop_mul; // rest of the m extension is not supported
        end
      end
      `IMM_OPCODE: begin
        case (funct3)
          `ADD_FUNCT3:  op = iop_addi;
          `SLT_FUNCT3:  op = iop_slti;
          `SLTU_FUNCT3: op = iop_sltiu;
          `XOR_FUNCT3:  op = iop_xori;
          `OR_FUNCT3:   op = iop_ori;
          `AND_FUNCT3:  op = iop_andi;
          `SLL_FUNCT3:  op = (funct7 == `BASE_FUNCT7) ? iop_slli : iop_invalid;
          `SRL_FUNCT3: begin
            if (funct7 == `BASE_FUNCT7)
              op = iop_srli;
            else if (funct7 == `SUB_FUNCT7)
              op = iop_srai;
          end
          default: op = iop_invalid;
        endcase
      end
      `BRANCH_OPCODE: begin
        case (funct3)
          `BEQ_FUNCT3:  op = iop_beq;
          `BNE_FUNCT3:  op = iop_bne;
          `BLT_FUNCT3:  op = iop_blt;
          `BGE_FUNCT3:  op = iop_bge;
          `BLTU_FUNCT3: op = iop_bltu;
          `BGEU_FUNCT3: op = iop_bgeu;
          default:      op = iop_invalid; // 010, 011 unused
        endcase
      end
      `LUI_OPCODE:   op = iop_lui;
      `AUIPC_OPCODE: op = iop_auipc;
      `JAL_OPCODE:   op = iop_jal;
      `JALR_OPCODE:  op = (funct3 == `JALR_FUNCT3) ? iop_jalr : iop_invalid;
      `LW_OPCODE:    op = (funct3 == `LW_FUNCT3) ? iop_lw : iop_invalid;
      `SW_OPCODE:    op = (funct3 == `SW_FUNCT3) ? iop_sw : iop_invalid;
      default:       op = iop_invalid;
    endcase
  end

  always_comb begin
    case (op)
      iop_add, iop_sub, iop_and, iop_or, iop_xor, iop_slt, iop_sltu,
      iop_sra, iop_srl, iop_sll, iop_mul:
        fmt = fmt_r;
      iop_addi, iop_andi, iop_ori, iop_xori, iop_slti, iop_sltiu,
      iop_srai, iop_srli, iop_slli, iop_lw, iop_jalr:
        fmt = fmt_i;
      iop_beq, iop_bne, iop_blt, iop_bge, iop_bltu, iop_bgeu:
        fmt = fmt_b;
      iop_sw:              fmt = fmt_s;
      iop_lui, iop_auipc:  fmt = fmt_u;
      iop_jal:             fmt = fmt_j;
      default:             fmt = fmt_none;
    endcase
  end

  // register fields that are real for each format
  always_comb begin
    imm_kind = imm_none;
    uses_rs1 = 1'b0;
    uses_rs2 = 1'b0;
    wr_reg   = 1'b0;
    case (fmt)
      fmt_r: begin
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
        wr_reg   = 1'b1;
      end
      fmt_i: begin
        imm_kind = imm_i; // shift amounts come out of the i immediate too
        uses_rs1 = 1'b1;
        wr_reg   = 1'b1;
      end
      fmt_s, fmt_b: begin
        imm_kind = (fmt == fmt_s) ? imm_s : imm_b;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
      end
      fmt_u: begin
        imm_kind = imm_u;
        wr_reg   = 1'b1;
      end
      fmt_j: begin
        imm_kind = imm_j;
        wr_reg   = 1'b1;
      end
      default: imm_kind = imm_none; // invalid touches no registers
    endcase
  end

endmodule

`default_nettype wire

/* decode/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "decode_params.svh"

module reg_file import decode_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [`REGNOBITS-1:0] rs1,
  input  logic [`REGNOBITS-1:0] rs2,
  output logic [`DBITS-1:0]     rs1_val,
  output logic [`DBITS-1:0]     rs2_val,
  input  wb_to_de_t             wb
);

  logic [`DBITS-1:0] regs [`REGWORDS];

  // x0 reads zero, a write-back in flight is bypassed to the reader
  function automatic logic [`DBITS-1:0] read_port(input logic [`REGNOBITS-1:0] idx);
    if (idx == '0)
      return '0;
    else if (wb.wr_reg && wb.wregno == idx)
      return wb.regval;
    else
      return regs[idx];
  endfunction

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `REGWORDS; i++)
        regs[i] <= '0;
    end else if (wb.wr_reg && wb.wregno != '0) begin
      regs[wb.wregno] <= wb.regval;
    end
  end

  assign rs1_val = read_port(rs1);
  assign rs2_val = read_port(rs2);

endmodule

`default_nettype wire

/* flist.f */
+incdir+common
common/decode_pkg.sv
decode/instr_decoder.sv
decode/imm_gen.sv
decode/reg_file.sv
decode/hazard_scoreboard.sv
decode/decode_stage.sv
bench/decode_tb.sv
